/* rtl/lsu_bus_pkg.sv */
// Data bus definitions for the load/store unit
// Word, byte-enable and byte-offset types shared by the RTL and the bench
package lsu_bus_pkg;

  //////////////////////////////
  // Bus geometry
  //////////////////////////////

  // Data and address width of the bus
  parameter int unsigned DATA_W = 32;

  // One enable per byte lane
  parameter int unsigned BE_W = DATA_W / 8;

  // Address step between two adjacent bus words
  parameter int unsigned BYTES_PER_WORD = BE_W;

  //////////////////////////////
  // Bus types
  //////////////////////////////

  // Data word, also used for addresses
  typedef logic [DATA_W-1:0] word_t;

  // Byte-enable mask, bit i selects lane i
  typedef logic [BE_W-1:0] be_t;

  // Byte position inside a word
  typedef logic [$clog2(BE_W)-1:0] offset_t;

endpackage

/* rtl/lsu_op_pkg.sv */
// Load/store operation definitions
// Access-size encoding and the split rule shared by the request and realignment logic
package lsu_op_pkg;

  import lsu_bus_pkg::*;

  // Access size as given by the execute stage
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Access crosses a word boundary and needs two bus transfers
  // Halfword at offset 1 stays inside the word
  function automatic logic needs_split(lsu_size_e size, offset_t offset);
    logic word_split;
    logic half_split;
    word_split = (size == SIZE_WORD) && (offset != '0);
    half_split = (size == SIZE_HALF) && (offset == '1);
    return word_split || half_split;
  endfunction

endpackage

/* rtl/lsu_req_if.sv */
`timescale 1ns/10ps
// Internal links of the load/store unit
// lsu_req_if carries one bus transfer from the request generator to the tracker,
// lsu_resp_if carries address-phase and response events from the tracker to the aligner
interface lsu_req_if import lsu_bus_pkg::*; ();

  logic  valid;
  logic  ready;
  word_t addr;
  logic  we;
  be_t   be;
  word_t wdata;
  // First part of a split access
  logic  split;

  modport gen (
    output valid, addr, we, be, wdata, split,
    input  ready
  );

  modport trk (
    input  valid, addr, we, be, wdata, split,
    output ready
  );

endinterface

interface lsu_resp_if import lsu_bus_pkg::*; ();

  // Address phase of the execute-side part is done
  logic  accept;
  logic  first_part;
  // Response straight from the bus
  logic  rvalid;
  word_t rdata;

  modport trk (
    output accept, first_part, rvalid, rdata
  );

  modport aln (
    input  accept, first_part, rvalid, rdata
  );

endinterface

/* rtl/lsu_request_gen.sv */
`timescale 1ns/10ps
// Request generator of the load/store unit
// Forms the effective address, byte enables and lane-rotated store data,
// and walks a misaligned access through its two bus transfers
module lsu_request_gen
  import lsu_bus_pkg::*;
  import lsu_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid_i,
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  logic      we_i,
  input  lsu_size_e size_i,
  input  word_t     wdata_i,
  input  logic      accept_i,
  lsu_req_if.gen    req
);

  word_t   eff_addr;
  offset_t offset;
  word_t   next_word;
  logic    split_q;
  logic    first_split;
  be_t     be;
  word_t   wdata_rot;

  //////////////////////////////
  // Address
  //////////////////////////////

  assign eff_addr = op_a_i + op_b_i;
  assign offset   = eff_addr[1:0];

  // Second part always targets the following aligned word
  assign next_word = {eff_addr[31:2], 2'b00} + word_t'(BYTES_PER_WORD);

  // Only the first transfer of a crossing access is flagged
  assign first_split = valid_i && !split_q && needs_split(size_i, offset);

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  always_comb begin
    case (size_i)
      SIZE_BYTE: begin
        be = 4'b0001 << offset;
      end
      SIZE_HALF: begin
        // Only offset 3 gets here with split_q set, upper byte goes to lane 0
        if (split_q) begin
          be = 4'b0001;
        end else begin
          be = 4'b0011 << offset;
        end
      end
      default: begin
        // Word, first part takes the upper lanes and second part the rest
        if (split_q) begin
          be = ~(4'b1111 << offset);
        end else begin
          be = 4'b1111 << offset;
        end
      end
    endcase
  end

  //////////////////////////////
  // Store data
  //////////////////////////////

  // Rotate left by the offset so byte 0 of the operand lands in the addressed lane
  // Same rotation serves both parts of a split store
  always_comb begin
    case (offset)
      2'd1:    wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      2'd3:    wdata_rot = {wdata_i[7:0],  wdata_i[31:8]};
      default: wdata_rot = wdata_i;
    endcase
  end

  // Split state, high while the second part is being requested
  // Dropped valid returns to the first part for the next access
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_i) begin
      split_q <= 1'b0;
    end else if (accept_i) begin
      split_q <= first_split;
    end
  end

  // Transfer towards the tracker
  assign req.valid = valid_i;
  assign req.addr  = split_q ? next_word : eff_addr;
  assign req.we    = we_i;
  assign req.be    = be;
  assign req.wdata = wdata_rot;
  assign req.split = first_split;

endmodule

/* rtl/lsu_txn_tracker.sv */
`timescale 1ns/10ps
// Transaction tracker of the load/store unit
// Drives the request/grant/response bus, bounds outstanding transfers to DEPTH
// and produces the execute-side ready
module lsu_txn_tracker
  import lsu_bus_pkg::*;
#(
  parameter int DEPTH = 2
) (
  input  logic    clk,
  input  logic    rst_n,
  lsu_req_if.trk  req,
  lsu_resp_if.trk resp,
  output logic    req_o,
  input  logic    gnt_i,
  output word_t   addr_o,
  output logic    we_o,
  output be_t     be_o,
  output word_t   wdata_o,
  input  logic    rvalid_i,
  input  word_t   rdata_i,
  output logic    ready_o,
  output logic    busy_o
);

  // Count must reach DEPTH itself
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             cnt_full;
  logic             grant;

  //////////////////////////////
  // Bus request
  //////////////////////////////

  // Full count holds the request back until a response lowers it
  assign cnt_full = (cnt_q == CNT_W'(DEPTH));
  assign req_o    = req.valid && !cnt_full;

  // Transfer moves on the bus grant
  assign req.ready = gnt_i && !cnt_full;
  assign grant     = req.valid && req.ready;

  // Generator holds these stable until the grant
  assign addr_o  = req.addr;
  assign we_o    = req.we;
  assign be_o    = req.be;
  assign wdata_o = req.wdata;

  //////////////////////////////
  // Outstanding count
  //////////////////////////////

  // Up on grant and down on response
  // Both in one cycle keep the count
  always_comb begin
    case ({grant, rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////
  // Aligner side
  //////////////////////////////

  assign resp.accept     = grant;
  assign resp.first_part = req.split;
  assign resp.rvalid     = rvalid_i;
  assign resp.rdata      = rdata_i;

  // Idle execute stage is always ready
  // First grant of a split keeps ready low so the second part follows
  assign ready_o = !req.valid || (grant && !req.split);

  assign busy_o = (cnt_q != '0) || req.valid;

endmodule

/* rtl/lsu_rdata_align.sv */
`timescale 1ns/10ps
// Load data aligner
// Holds the attributes of the accepted access, joins the two halves of a split
// load and returns the realigned, zero- or sign-extended result
module lsu_rdata_align
  import lsu_bus_pkg::*;
  import lsu_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  lsu_resp_if.aln   resp,
  input  lsu_size_e size_i,
  input  logic      sext_i,
  input  logic      we_i,
  input  offset_t   offset_i,
  output word_t     rdata_o,
  output logic      load_valid_o
);

  lsu_size_e                    size_q;
  logic                         sext_q;
  logic                         we_q;
  offset_t                      offset_q;
  logic                         last_q;
  word_t                        raw_q;
  logic                         split_load;
  logic [2*$bits(word_t)-1:0]   joined;
  word_t                        shifted;

  // Attributes of the access in its data phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      size_q   <= SIZE_WORD;
      sext_q   <= 1'b0;
      we_q     <= 1'b0;
      offset_q <= '0;
      last_q   <= 1'b1;
    end else if (resp.accept) begin
      size_q <= size_i;
      sext_q <= sext_i;
      we_q   <= we_i;
      // Second part carries an aligned address, keep the offset of the first
      if (last_q) begin
        offset_q <= offset_i;
      end
      last_q <= !resp.first_part;
    end
  end

  // Lower half of a split load waits here for the second response
  always_ff @(posedge clk) begin
    if (resp.rvalid && !last_q) begin
      raw_q <= resp.rdata;
    end
  end

  //////////////////////////////
  // Realign and extend
  //////////////////////////////

  assign split_load = needs_split(size_q, offset_q);

  // Unsplit access doubles the word so the shift wraps the upper lanes around
  assign joined  = split_load ? {resp.rdata, raw_q} : {resp.rdata, resp.rdata};
  assign shifted = word_t'(joined >> {offset_q, 3'b000});

  always_comb begin
    case (size_q)
      SIZE_BYTE: rdata_o = {{24{sext_q && shifted[7]}}, shifted[7:0]};
      SIZE_HALF: rdata_o = {{16{sext_q && shifted[15]}}, shifted[15:0]};
      default:   rdata_o = shifted;
    endcase
  end

  // One pulse per load, on its final response
  assign load_valid_o = resp.rvalid && last_q && !we_q;

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/10ps
// Load/store unit top level
// Execute-side valid/ready inputs on one side, request/grant/response data bus on the other
module lsu_top
  import lsu_bus_pkg::*;
  import lsu_op_pkg::*;
#(
  parameter int DEPTH = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  // Execute stage
  input  logic      valid_i,
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  logic      we_i,
  input  lsu_size_e size_i,
  input  logic      sext_i,
  input  word_t     wdata_i,
  output logic      ready_o,
  // Load result
  output word_t     rdata_o,
  output logic      load_valid_o,
  output logic      busy_o,
  // Data bus
  output logic      req_o,
  input  logic      gnt_i,
  output word_t     addr_o,
  output logic      we_o,
  output be_t       be_o,
  output word_t     wdata_o,
  input  logic      rvalid_i,
  input  word_t     rdata_i
);

  lsu_req_if  req_bus ();
  lsu_resp_if resp_bus ();

  //////////////////////////////
  // Request side
  //////////////////////////////

  lsu_request_gen req_gen_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .we_i     (we_i),
    .size_i   (size_i),
    .wdata_i  (wdata_i),
    .accept_i (resp_bus.accept),
    .req      (req_bus.gen)
  );

  lsu_txn_tracker #(
    .DEPTH (DEPTH)
  ) txn_trk_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req_bus.trk),
    .resp    (resp_bus.trk),
    .req_o   (req_o),
    .gnt_i   (gnt_i),
    .addr_o  (addr_o),
    .we_o    (we_o),
    .be_o    (be_o),
    .wdata_o (wdata_o),
    .rvalid_i(rvalid_i),
    .rdata_i (rdata_i),
    .ready_o (ready_o),
    .busy_o  (busy_o)
  );

  //////////////////////////////
  // Response side
  //////////////////////////////

  // Offset taken from the bus address, the aligner ignores it on second parts
  lsu_rdata_align rdata_aln_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .resp         (resp_bus.aln),
    .size_i       (size_i),
    .sext_i       (sext_i),
    .we_i         (we_i),
    .offset_i     (req_bus.addr[1:0]),
    .rdata_o      (rdata_o),
    .load_valid_o (load_valid_o)
  );

endmodule

/* bench/lsu_mem_model.sv */
`timescale 1ns/10ps
// Behavioural data memory for the load/store unit bench
// Grants after an LFSR-drawn stall of 0 to 3 cycles and responds one cycle after the grant
module lsu_mem_model
  import lsu_bus_pkg::*;
#(
  parameter int WORDS = 64
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_i,
  output logic  gnt_o,
  input  word_t addr_i,
  input  logic  we_i,
  input  be_t   be_i,
  input  word_t wdata_i,
  output logic  rvalid_o,
  output word_t rdata_o
);

  localparam logic [15:0] LFSR_SEED = 16'd39109;

  word_t                    mem [WORDS];
  logic [15:0]              lfsr_q;
  logic [15:0]              lfsr_1;
  logic [15:0]              lfsr_2;
  logic [1:0]               stall;
  logic                     armed_q;
  logic [1:0]               wait_q;
  logic [$clog2(WORDS)-1:0] idx;

  // Fibonacci LFSR, taps 16 14 13 11, new bit enters at the bottom
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Initial content, one value per byte address
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'(a * 37) ^ 8'h5A;
  endfunction

  // Two steps, one per stall bit
  assign lfsr_1 = lfsr_next(lfsr_q);
  assign lfsr_2 = lfsr_next(lfsr_1);
  assign stall  = {lfsr_1[0], lfsr_2[0]};
  assign idx    = addr_i[$clog2(WORDS)+1:2];

  //////////////////////////////
  // Grant and response
  //////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      armed_q  <= 1'b0;
      wait_q   <= '0;
      lfsr_q   <= LFSR_SEED;
      for (int w = 0; w < WORDS; w++) begin
        for (int b = 0; b < BE_W; b++) begin
          mem[w][8*b +: 8] <= fill_byte(4 * w + b);
        end
      end
    end else begin
      rvalid_o <= 1'b0;
      if (gnt_o) begin
        // Grant taken at this edge, access the array now
        gnt_o <= 1'b0;
        if (req_i) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[idx];
          if (we_i) begin
            for (int b = 0; b < BE_W; b++) begin
              if (be_i[b]) begin
                mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
              end
            end
          end
        end
      end else if (req_i && !armed_q) begin
        // New request, draw its stall
        lfsr_q  <= lfsr_2;
        wait_q  <= stall;
        armed_q <= (stall != 2'd0);
        gnt_o   <= (stall == 2'd0);
      end else if (req_i) begin
        wait_q <= wait_q - 2'd1;
        if (wait_q == 2'd1) begin
          gnt_o   <= 1'b1;
          armed_q <= 1'b0;
        end
      end
    end
  end

endmodule

/* bench/lsu_tb.sv */
`timescale 1ns/10ps
// Table-driven testbench for the load/store unit
// Runs loads and stores against a stalling memory and checks bus transfers and load data
module lsu_tb
  import lsu_bus_pkg::*;
  import lsu_op_pkg::*;
();

  localparam int NUM_OPS     = 22;
  localparam int TIMEOUT_CYC = 40;

  typedef struct packed {
    word_t     op_a;
    word_t     op_b;
    logic      we;
    lsu_size_e size;
    logic      sext;
    word_t     wdata;
    word_t     exp;
  } op_t;

  // op_a, op_b, we, size, sext, store data, expected load value
  localparam op_t OPS [NUM_OPS] = '{
    '{32'h10, 32'h0, 1'b1, SIZE_WORD, 1'b0, 32'h11223344, 32'h0},
    '{32'h10, 32'h0, 1'b0, SIZE_WORD, 1'b0, 32'h0,        32'h11223344},
    '{32'h20, 32'h2, 1'b1, SIZE_HALF, 1'b0, 32'hFFFF8765, 32'h0},
    '{32'h20, 32'h2, 1'b0, SIZE_HALF, 1'b0, 32'h0,        32'h00008765},
    '{32'h21, 32'h1, 1'b0, SIZE_HALF, 1'b1, 32'h0,        32'hFFFF8765},
    '{32'h30, 32'h1, 1'b1, SIZE_BYTE, 1'b0, 32'hDEADBEA5, 32'h0},
    '{32'h30, 32'h1, 1'b0, SIZE_BYTE, 1'b0, 32'h0,        32'h000000A5},
    '{32'h31, 32'h0, 1'b0, SIZE_BYTE, 1'b1, 32'h0,        32'hFFFFFFA5},
    '{32'h30, 32'h2, 1'b1, SIZE_BYTE, 1'b0, 32'h0000005C, 32'h0},
    '{32'h30, 32'h2, 1'b0, SIZE_BYTE, 1'b1, 32'h0,        32'h0000005C},
    '{32'h40, 32'h1, 1'b1, SIZE_WORD, 1'b0, 32'hCAFEF00D, 32'h0},
    '{32'h3F, 32'h2, 1'b0, SIZE_WORD, 1'b0, 32'h0,        32'hCAFEF00D},
    '{32'h48, 32'h2, 1'b1, SIZE_WORD, 1'b0, 32'h89ABCDEF, 32'h0},
    '{32'h48, 32'h2, 1'b0, SIZE_WORD, 1'b0, 32'h0,        32'h89ABCDEF},
    '{32'h50, 32'h3, 1'b1, SIZE_WORD, 1'b0, 32'h01234567, 32'h0},
    '{32'h50, 32'h3, 1'b0, SIZE_WORD, 1'b0, 32'h0,        32'h01234567},
    '{32'h60, 32'h3, 1'b1, SIZE_HALF, 1'b0, 32'h0000BEEF, 32'h0},
    '{32'h60, 32'h3, 1'b0, SIZE_HALF, 1'b1, 32'h0,        32'hFFFFBEEF},
    '{32'h68, 32'h1, 1'b1, SIZE_HALF, 1'b0, 32'h00007A55, 32'h0},
    '{32'h68, 32'h1, 1'b0, SIZE_HALF, 1'b1, 32'h0,        32'h00007A55},
    '{32'h68, 32'h2, 1'b0, SIZE_BYTE, 1'b1, 32'h0,        32'h0000007A},
    '{32'h63, 32'h0, 1'b0, SIZE_HALF, 1'b0, 32'h0,        32'h0000BEEF}
  };

  logic      clk;
  logic      rst_n;
  logic      valid_i;
  word_t     op_a_i;
  word_t     op_b_i;
  logic      we_i;
  lsu_size_e size_i;
  logic      sext_i;
  word_t     wdata_i;
  logic      ready_o;
  word_t     rdata_o;
  logic      load_valid_o;
  logic      busy_o;
  logic      req_o;
  logic      gnt_i;
  word_t     addr_o;
  logic      we_o;
  be_t       be_o;
  word_t     wdata_o;
  logic      rvalid_i;
  word_t     rdata_i;

  int          errors;
  int          checks;
  int          load_pulses;
  int          num_loads;
  logic        timed_out;
  word_t       load_data;
  logic [7:0]  ref_mem [256];
  word_t       gnt_addr [$];
  be_t         gnt_be [$];
  logic        gnt_we [$];
  word_t       gnt_wdata [$];

  lsu_top #(.DEPTH(2)) lsu_top_i (.*);

  lsu_mem_model mem_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (req_o),
    .gnt_o    (gnt_i),
    .addr_i   (addr_o),
    .we_i     (we_o),
    .be_i     (be_o),
    .wdata_i  (wdata_o),
    .rvalid_o (rvalid_i),
    .rdata_o  (rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Bus monitor
  //////////////////////////////

  always @(posedge clk) begin
    if (req_o && gnt_i) begin
      gnt_addr.push_back(addr_o);
      gnt_be.push_back(be_o);
      gnt_we.push_back(we_o);
      gnt_wdata.push_back(wdata_o);
    end
    if (load_valid_o) begin
      load_pulses++;
    end
  end

  // Same content as the memory model after reset
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'(a * 37) ^ 8'h5A;
  endfunction

  task automatic compare(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Waits for ready_o, load_valid_o or an idle unit at the rising edge
  task automatic wait_signal(input string what);
    int   cyc;
    logic seen;
    cyc  = 0;
    seen = 1'b0;
    while (!seen && cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      case (what)
        "ready_o":      seen = ready_o;
        "load_valid_o": seen = load_valid_o;
        default:        seen = !busy_o;
      endcase
      load_data = rdata_o;
      cyc++;
    end
    if (!seen) begin
      $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYC, what);
      timed_out = 1'b1;
    end
  endtask

  // Load value from the byte model extended to the access size
  function automatic word_t model_load(input word_t addr, input lsu_size_e size,
                                       input logic sext);
    word_t bytes;
    for (int b = 0; b < 4; b++) begin
      bytes[8*b +: 8] = ref_mem[(addr + b) & 32'hFF];
    end
    case (size)
      SIZE_BYTE: return {{24{sext && bytes[7]}}, bytes[7:0]};
      SIZE_HALF: return {{16{sext && bytes[15]}}, bytes[15:0]};
      default:   return bytes;
    endcase
  endfunction

  task automatic run_op(input op_t op);
    word_t       eaddr;
    int          nbytes;
    int          nparts;
    logic [7:0]  mask;
    logic [63:0] lanes;
    logic [63:0] lane_bits;
    gnt_addr.delete();
    gnt_be.delete();
    gnt_we.delete();
    gnt_wdata.delete();
    eaddr  = op.op_a + op.op_b;
    nbytes = (op.size == SIZE_BYTE) ? 1 : (op.size == SIZE_HALF) ? 2 : 4;
    // Access that runs past byte 3 takes a second transfer at the next word
    nparts = (int'(eaddr[1:0]) + nbytes > 4) ? 2 : 1;
    mask   = 8'((1 << nbytes) - 1) << eaddr[1:0];
    // Store byte i belongs at address eaddr + i over two consecutive words
    lanes  = 64'(op.wdata) << (8 * eaddr[1:0]);
    for (int b = 0; b < 8; b++) begin
      lane_bits[8*b +: 8] = {8{mask[b]}};
    end
    @(posedge clk);
    #1;
    valid_i = 1'b1;
    op_a_i  = op.op_a;
    op_b_i  = op.op_b;
    we_i    = op.we;
    size_i  = op.size;
    sext_i  = op.sext;
    wdata_i = op.wdata;
    wait_signal("ready_o");
    #1;
    valid_i = 1'b0;
    if (!op.we && !timed_out) begin
      wait_signal("load_valid_o");
    end
    if (!timed_out) begin
      wait_signal("idle");
    end
    if (!timed_out) begin
      compare("grant count", gnt_addr.size(), nparts);
      if (gnt_addr.size() >= nparts) begin
        compare("addr_o", gnt_addr[0], eaddr);
        compare("be_o", gnt_be[0], mask[3:0]);
        if (nparts == 2) begin
          // Next word starts one past the last byte of this one
          compare("addr_o", gnt_addr[1], (eaddr | 32'h3) + 32'd1);
          compare("be_o", gnt_be[1], mask[7:4]);
        end
        // Each part carries the write flag and a store puts its bytes in the enabled lanes
        for (int p = 0; p < nparts; p++) begin
          compare("we_o", gnt_we[p], op.we);
          if (op.we) begin
            compare("wdata_o", gnt_wdata[p] & lane_bits[32*p +: 32],
                    lanes[32*p +: 32] & lane_bits[32*p +: 32]);
          end
        end
      end
      if (op.we) begin
        for (int b = 0; b < nbytes; b++) begin
          ref_mem[(eaddr + b) & 32'hFF] = op.wdata[8*b +: 8];
        end
      end else begin
        compare("rdata_o", load_data, op.exp);
        compare("rdata_o", load_data, model_load(eaddr, op.size, op.sext));
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    errors      = 0;
    checks      = 0;
    load_pulses = 0;
    num_loads   = 0;
    timed_out   = 1'b0;
    load_data   = '0;
    rst_n       = 1'b0;
    valid_i     = 1'b0;
    op_a_i      = '0;
    op_b_i      = '0;
    we_i        = 1'b0;
    size_i      = SIZE_BYTE;
    sext_i      = 1'b0;
    wdata_i     = '0;
    for (int a = 0; a < 256; a++) begin
      ref_mem[a] = fill_byte(a);
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    compare("req_o", req_o, 1'b0);
    compare("load_valid_o", load_valid_o, 1'b0);
    compare("busy_o", busy_o, 1'b0);
    for (int i = 0; i < NUM_OPS && !timed_out; i++) begin
      if (!OPS[i].we) begin
        num_loads++;
      end
      run_op(OPS[i]);
    end
    // Stores must leave no pulse behind and the unit must be idle
    if (!timed_out) begin
      repeat (2) @(posedge clk);
      compare("load_valid_o pulses", load_pulses, num_loads);
      compare("busy_o", busy_o, 1'b0);
    end
    $display("Checks run: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
rtl/lsu_bus_pkg.sv
rtl/lsu_op_pkg.sv
rtl/lsu_req_if.sv
rtl/lsu_request_gen.sv
rtl/lsu_txn_tracker.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
bench/lsu_mem_model.sv
bench/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - rtl/lsu_bus_pkg.sv
  - rtl/lsu_op_pkg.sv
  - rtl/lsu_req_if.sv
  - rtl/lsu_request_gen.sv
  - rtl/lsu_txn_tracker.sv
  - rtl/lsu_rdata_align.sv
  - rtl/lsu_top.sv
  - target: test
    files:
      - bench/lsu_mem_model.sv
      - bench/lsu_tb.sv
